// ==== Bender.yml ====
package:
  name: pipe_long

sources:
  - src/rv_arith_pkg.sv
  - src/long_pipe_pkg.sv
  - src/iter_unit_if.sv
  - src/imulh_iterative.sv
  - src/idiv_iterative.sv
  - src/long_pipe_ctrl.sv
  - src/pipe_long_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_pipe_long.sv

// ==== src/idiv_iterative.sv ====
`default_nettype none

module idiv_iterative
  import rv_arith_pkg::*;
  import long_pipe_pkg::*;
  (input  logic      clk_i
   , input logic     reset_i
   , iter_unit_if.unit port
   );

  iter_state_e                  state_r;
  logic [iter_cnt_width_gp-1:0] cnt_r;
  logic [dword_width_gp-1:0]    quo_r;  // Dividend shifts out as quotient shifts in
  logic [dword_width_gp-1:0]    dvs_r;
  logic [dword_width_gp-1:0]    rem_r;
  logic                         sgn_r;
  logic                         q_neg_r;
  logic                         r_neg_r;

  wire accept    = port.v & port.ready;
  wire busy      = (state_r == e_busy);
  wire load_step = busy & (cnt_r == '0);
  wire fix_step  = busy & (cnt_r == iter_fix_cnt_gp);

  wire neg_a = sgn_r & quo_r[dword_width_gp-1];
  wire neg_b = sgn_r & dvs_r[dword_width_gp-1];

  // Top bit of the trial subtract is the borrow
  wire [dword_width_gp+1:0] diff = {1'b0, rem_r, quo_r[dword_width_gp-1]}
                                   - {2'b00, dvs_r};
  wire                      borrow = diff[dword_width_gp+1];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_idle;
      cnt_r   <= '0;
    end
    else
    begin
      case (state_r)
        e_idle:
          if (accept)
          begin
            state_r <= e_busy;
            cnt_r   <= '0;
          end
        e_busy:
        begin
          cnt_r <= cnt_r + 1'b1;
          if (fix_step)
            state_r <= e_done;
        end
        e_done:
          if (port.yumi)
            state_r <= e_idle;
        default: state_r <= e_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      quo_r <= port.op_a;
      dvs_r <= port.op_b;
      sgn_r <= port.signed_a;
    end
    else if (load_step)
    begin
      quo_r   <= neg_a ? -quo_r : quo_r;
      dvs_r   <= neg_b ? -dvs_r : dvs_r;
      rem_r   <= '0;
      // Divide by zero keeps the all-ones quotient
      q_neg_r <= (neg_a ^ neg_b) & (dvs_r != '0);
      r_neg_r <= neg_a;
    end
    else if (fix_step)
    begin
      quo_r <= q_neg_r ? -quo_r : quo_r;
      rem_r <= r_neg_r ? -rem_r : rem_r; // Remainder follows the dividend
    end
    else if (busy)
    begin
      if (borrow)
      begin
        rem_r <= {rem_r[dword_width_gp-2:0], quo_r[dword_width_gp-1]};
        quo_r <= {quo_r[dword_width_gp-2:0], 1'b0};
      end
      else
      begin
        rem_r <= diff[dword_width_gp-1:0];
        quo_r <= {quo_r[dword_width_gp-2:0], 1'b1};
      end
    end
  end

  assign port.ready  = (state_r == e_idle);
  assign port.res_v  = (state_r == e_done);
  assign port.res_hi = quo_r;
  assign port.res_lo = rem_r;

endmodule

`default_nettype wire

// ==== src/imulh_iterative.sv ====
`default_nettype none

module imulh_iterative
  import rv_arith_pkg::*;
  import long_pipe_pkg::*;
  (input  logic      clk_i
   , input logic     reset_i
   , iter_unit_if.unit port
   );

  iter_state_e                    state_r;
  logic [iter_cnt_width_gp-1:0]   cnt_r;
  logic [dword_width_gp-1:0]      a_r;
  logic [dword_width_gp-1:0]      b_r;  // Multiplier consumed LSB first
  logic                           sa_r;
  logic                           sb_r;
  logic                           neg_r;
  logic [2*dword_width_gp-1:0]    prod_r;

  wire accept    = port.v & port.ready;
  wire busy      = (state_r == e_busy);
  wire load_step = busy & (cnt_r == '0);
  wire fix_step  = busy & (cnt_r == iter_fix_cnt_gp);

  wire neg_a = sa_r & a_r[dword_width_gp-1];
  wire neg_b = sb_r & b_r[dword_width_gp-1];

  // One shift-add step on the upper half
  wire [dword_width_gp-1:0] addend = b_r[0] ? a_r : '0;
  wire [dword_width_gp:0]   acc_sum = {1'b0, prod_r[2*dword_width_gp-1 -: dword_width_gp]}
                                      + {1'b0, addend};

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_idle;
      cnt_r   <= '0;
    end
    else
    begin
      case (state_r)
        e_idle:
          if (accept)
          begin
            state_r <= e_busy;
            cnt_r   <= '0;
          end
        e_busy:
        begin
          cnt_r <= cnt_r + 1'b1;
          if (fix_step)
            state_r <= e_done;
        end
        e_done:
          if (port.yumi)
            state_r <= e_idle;
        default: state_r <= e_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      a_r  <= port.op_a;
      b_r  <= port.op_b;
      sa_r <= port.signed_a;
      sb_r <= port.signed_b;
    end
    else if (load_step)
    begin
      a_r    <= neg_a ? -a_r : a_r; // Magnitudes
      b_r    <= neg_b ? -b_r : b_r;
      neg_r  <= neg_a ^ neg_b;
      prod_r <= '0;
    end
    else if (fix_step)
      prod_r <= neg_r ? -prod_r : prod_r;
    else if (busy)
    begin
      prod_r <= {acc_sum, prod_r[dword_width_gp-1:1]};
      b_r    <= b_r >> 1;
    end
  end

  assign port.ready  = (state_r == e_idle);
  assign port.res_v  = (state_r == e_done);
  assign port.res_hi = prod_r[2*dword_width_gp-1 -: dword_width_gp];
  assign port.res_lo = prod_r[dword_width_gp-1:0];

endmodule

`default_nettype wire

// ==== src/iter_unit_if.sv ====
`default_nettype none

interface iter_unit_if
  import rv_arith_pkg::*;
  ();

  // Request side
  logic                      v;
  logic                      ready;
  logic [dword_width_gp-1:0] op_a;
  logic [dword_width_gp-1:0] op_b;
  logic                      signed_a;
  logic                      signed_b;

  // Result side held until yumi
  logic                      res_v;
  logic [dword_width_gp-1:0] res_hi;
  logic [dword_width_gp-1:0] res_lo;
  logic                      yumi;

  modport issuer
    (output v, op_a, op_b, signed_a, signed_b, yumi
     , input ready, res_v, res_hi, res_lo
     );

  modport unit
    (input v, op_a, op_b, signed_a, signed_b, yumi
     , output ready, res_v, res_hi, res_lo
     );

endinterface

`default_nettype wire

// ==== src/long_pipe_ctrl.sv ====
`default_nettype none

module long_pipe_ctrl
  import rv_arith_pkg::*;
  import long_pipe_pkg::*;
  (input  logic                           clk_i
   , input logic                          reset_i

   , input logic                          issue_v_i
   , input long_op_e                      fu_op_i
   , input logic                          opw_i
   , input logic [dword_width_gp-1:0]     rs1_i
   , input logic [dword_width_gp-1:0]     rs2_i
   , input logic [reg_addr_width_gp-1:0]  rd_addr_i
   , output logic                         busy_o

   , iter_unit_if.issuer                  mul
   , iter_unit_if.issuer                  div

   , output long_wb_pkt_s                 wb_pkt_o
   , output logic                         wb_v_o
   , input logic                          wb_yumi_i
   );

  long_op_e                     fu_op_r;
  logic                         opw_r;
  logic [reg_addr_width_gp-1:0] rd_addr_r;
  logic                         wb_pend_r;
  logic                         wb_v_r;
  long_wb_pkt_s                 wb_pkt_r;
  logic [dword_width_gp-1:0]    rd_data_li;

  wire accept  = issue_v_i & ~busy_o;
  wire wb_take = wb_v_r & wb_yumi_i;
  wire is_mul  = fu_op_i inside {e_op_mulh, e_op_mulhsu, e_op_mulhu};

  // W forms run on the upper word of the 64-bit divider
  wire [dword_width_gp-1:0] op_a = opw_i ? (rs1_i << word_width_gp) : rs1_i;
  wire [dword_width_gp-1:0] op_b = opw_i ? (rs2_i << word_width_gp) : rs2_i;

  assign mul.v        = accept & is_mul;
  assign mul.op_a     = op_a;
  assign mul.op_b     = op_b;
  assign mul.signed_a = fu_op_i inside {e_op_mulh, e_op_mulhsu};
  assign mul.signed_b = (fu_op_i == e_op_mulh);
  assign mul.yumi     = mul.res_v & wb_take;

  assign div.v        = accept & ~is_mul;
  assign div.op_a     = op_a;
  assign div.op_b     = op_b;
  assign div.signed_a = fu_op_i inside {e_op_div, e_op_rem};
  assign div.signed_b = div.signed_a;
  assign div.yumi     = div.res_v & wb_take;

  wire [dword_width_gp-1:0] quot_w =
    {{(dword_width_gp-word_width_gp){div.res_hi[word_width_gp-1]}},
     div.res_hi[word_width_gp-1:0]};
  wire [dword_width_gp-1:0] rem_w = $signed(div.res_lo) >>> word_width_gp;

  always_comb
  begin
    case (fu_op_r)
      e_op_div, e_op_divu: rd_data_li = opw_r ? quot_w : div.res_hi;
      e_op_rem, e_op_remu: rd_data_li = opw_r ? rem_w : div.res_lo;
      default:             rd_data_li = mul.res_hi; // High product
    endcase
  end

  // First cycle of a unit result
  wire capture = (mul.res_v | div.res_v) & ~wb_v_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wb_pend_r <= 1'b0;
      wb_v_r    <= 1'b0;
    end
    else
    begin
      if (accept)
        wb_pend_r <= 1'b1;
      else if (wb_take)
        wb_pend_r <= 1'b0;

      if (capture)
        wb_v_r <= 1'b1;
      else if (wb_take)
        wb_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      fu_op_r   <= fu_op_i;
      opw_r     <= opw_i;
      rd_addr_r <= rd_addr_i;
    end
    if (capture)
      wb_pkt_r <= '{rd_addr: rd_addr_r, rd_data: rd_data_li};
  end

  // Single operation in flight
  assign busy_o   = ~mul.ready | ~div.ready | wb_pend_r;
  assign wb_v_o   = wb_v_r;
  assign wb_pkt_o = wb_pkt_r;

endmodule

`default_nettype wire

// ==== src/long_pipe_pkg.sv ====
`default_nettype none

package long_pipe_pkg;

  localparam int reg_addr_width_gp = 5;

  // Iterative unit step counter
  // Step 0 loads, steps 1 to 64 iterate, the last step fixes signs
  localparam int                         iter_cnt_width_gp = 7;
  localparam logic [iter_cnt_width_gp-1:0] iter_fix_cnt_gp = 7'd65;

  typedef struct packed
  {
    logic [reg_addr_width_gp-1:0] rd_addr;
    logic [63:0]                  rd_data;
  } long_wb_pkt_s;

  typedef enum logic [1:0]
  {
    e_idle
    , e_busy
    , e_done
  } iter_state_e;

endpackage

`default_nettype wire

// ==== src/pipe_long_top.sv ====
`default_nettype none

module pipe_long_top
  import rv_arith_pkg::*;
  import long_pipe_pkg::*;
  (input  logic                           clk_i
   , input logic                          reset_i

   , input logic                          issue_v_i
   , input long_op_e                      fu_op_i
   , input logic                          opw_i
   , input logic [dword_width_gp-1:0]     rs1_i
   , input logic [dword_width_gp-1:0]     rs2_i
   , input logic [reg_addr_width_gp-1:0]  rd_addr_i
   , output logic                         busy_o

   , output logic                         wb_v_o
   , output logic [reg_addr_width_gp-1:0] wb_rd_addr_o
   , output logic [dword_width_gp-1:0]    wb_data_o
   , input logic                          wb_yumi_i
   );

  iter_unit_if mul_link ();
  iter_unit_if div_link ();

  long_wb_pkt_s wb_pkt;

  long_pipe_ctrl ctrl
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.issue_v_i(issue_v_i)
     ,.fu_op_i(fu_op_i)
     ,.opw_i(opw_i)
     ,.rs1_i(rs1_i)
     ,.rs2_i(rs2_i)
     ,.rd_addr_i(rd_addr_i)
     ,.busy_o(busy_o)
     ,.mul(mul_link.issuer)
     ,.div(div_link.issuer)
     ,.wb_pkt_o(wb_pkt)
     ,.wb_v_o(wb_v_o)
     ,.wb_yumi_i(wb_yumi_i)
     );

  imulh_iterative imulh
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.port(mul_link.unit)
     );

  idiv_iterative idiv
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.port(div_link.unit)
     );

  assign wb_rd_addr_o = wb_pkt.rd_addr;
  assign wb_data_o    = wb_pkt.rd_data;

endmodule

`default_nettype wire

// ==== src/rv_arith_pkg.sv ====
`default_nettype none

package rv_arith_pkg;

  // RV64 integer datapath
  localparam int dword_width_gp = 64;
  localparam int word_width_gp  = 32; // W-form operand width

  // Operations handled by the long-latency pipe
  typedef enum logic [2:0]
  {
    e_op_mulh
    , e_op_mulhsu
    , e_op_mulhu
    , e_op_div
    , e_op_divu
    , e_op_rem
    , e_op_remu
  } long_op_e;

endpackage

`default_nettype wire

// ==== tb.f ====
src/rv_arith_pkg.sv
src/long_pipe_pkg.sv
src/iter_unit_if.sv
src/imulh_iterative.sv
src/idiv_iterative.sv
src/long_pipe_ctrl.sv
src/pipe_long_top.sv
verification/tb_clock_gen.sv
verification/tb_pipe_long.sv

// ==== verification/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen
  (output logic clk_o
   , output logic reset_o
   );

  timeunit 1ns;
  timeprecision 1ps;

  localparam int half_period_c = 5; // 10 ns clock
  localparam int reset_cycles_c = 5;

  initial
  begin
    clk_o = 1'b0;
    forever #half_period_c clk_o = ~clk_o;
  end

  initial
  begin
    reset_o = 1'b1;
    repeat (reset_cycles_c) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== verification/tb_pipe_long.sv ====
`default_nettype none

module tb_pipe_long
  import rv_arith_pkg::*;
  import long_pipe_pkg::*;
  ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_ops_c      = 80;
  localparam int latency_c    = 67;
  localparam int clk_period_c = 10;

  logic                         clk_i;
  logic                         reset_i;
  logic                         issue_v_i;
  long_op_e                     fu_op_i;
  logic                         opw_i;
  logic [dword_width_gp-1:0]    rs1_i;
  logic [dword_width_gp-1:0]    rs2_i;
  logic [reg_addr_width_gp-1:0] rd_addr_i;
  logic                         busy_o;
  logic                         wb_v_o;
  logic [reg_addr_width_gp-1:0] wb_rd_addr_o;
  logic [dword_width_gp-1:0]    wb_data_o;
  logic                         wb_yumi_i;

  long_wb_pkt_s                 exp_q[$];
  logic [dword_width_gp-1:0]    exp_data;
  logic [reg_addr_width_gp-1:0] exp_addr;
  logic [dword_width_gp-1:0]    prev_data;
  logic [reg_addr_width_gp-1:0] prev_addr;
  logic                         seen_issue = 1'b0;
  int                           exp_cnt = 0;
  int                           acc_cnt = 0;
  int                           wb_cnt = 0;
  int                           since_accept = 0;
  int                           err_cnt = 0;

  tb_clock_gen clock_gen (.clk_o(clk_i), .reset_o(reset_i));

  pipe_long_top DUT
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.issue_v_i(issue_v_i)
     ,.fu_op_i(fu_op_i)
     ,.opw_i(opw_i)
     ,.rs1_i(rs1_i)
     ,.rs2_i(rs2_i)
     ,.rd_addr_i(rd_addr_i)
     ,.busy_o(busy_o)
     ,.wb_v_o(wb_v_o)
     ,.wb_rd_addr_o(wb_rd_addr_o)
     ,.wb_data_o(wb_data_o)
     ,.wb_yumi_i(wb_yumi_i)
     );

  task automatic log_mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
    err_cnt++;
  endtask

  task automatic fail_check(input string what);
    $display("ERROR at %0t: %s", $time, what);
    err_cnt++;
  endtask

  // Expected result from the RISC-V M-extension rules
  function automatic logic [63:0] ref_result(input long_op_e op, input logic w,
                                             input logic [63:0] a, input logic [63:0] b);
    logic [127:0]       ext_a;
    logic [127:0]       ext_b;
    logic [127:0]       prod;
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] sa_w;
    logic signed [31:0] sb_w;
    logic [63:0]        q;
    logic [63:0]        r;
    logic [31:0]        q_w;
    logic [31:0]        r_w;
    logic               sgn;

    sgn = op inside {e_op_div, e_op_rem};
    if (op inside {e_op_mulh, e_op_mulhsu, e_op_mulhu})
    begin
      ext_a = (op != e_op_mulhu) ? {{64{a[63]}}, a} : {64'b0, a};
      ext_b = (op == e_op_mulh) ? {{64{b[63]}}, b} : {64'b0, b};
      prod  = ext_a * ext_b;
      return prod[127:64];
    end
    if (w)
    begin
      sa_w = a[31:0];
      sb_w = b[31:0];
      if (b[31:0] == '0)
      begin
        q_w = '1;
        r_w = a[31:0];
      end
      else if (sgn && a[31:0] == 32'h8000_0000 && b[31:0] == '1)
      begin
        q_w = a[31:0];
        r_w = '0;
      end
      else if (sgn)
      begin
        q_w = sa_w / sb_w;
        r_w = sa_w % sb_w;
      end
      else
      begin
        q_w = a[31:0] / b[31:0];
        r_w = a[31:0] % b[31:0];
      end
      q = {{32{q_w[31]}}, q_w};
      r = {{32{r_w[31]}}, r_w};
    end
    else
    begin
      sa = a;
      sb = b;
      if (b == '0)
      begin
        q = '1;
        r = a;
      end
      else if (sgn && a == 64'h8000_0000_0000_0000 && b == '1)
      begin
        q = a;
        r = '0;
      end
      else if (sgn)
      begin
        q = sa / sb;
        r = sa % sb;
      end
      else
      begin
        q = a / b;
        r = a % b;
      end
    end
    return (op inside {e_op_div, e_op_divu}) ? q : r;
  endfunction

  function automatic logic [63:0] pick_operand();
    case ($urandom_range(0, 5))
      0: return '0;
      1: return '1;
      2: return 64'h8000_0000_0000_0000;
      3: return 64'($urandom_range(1, 15));
      4: return -64'($urandom_range(1, 15)); // Small negative
      default: return {$urandom, $urandom};
    endcase
  endfunction

  // Issue one operation, optionally poke issue_v_i while busy, then take the writeback
  task automatic run_op(input long_op_e op, input logic w, input logic [63:0] a,
                        input logic [63:0] b, input int stall, input bit poke);
    @(posedge clk_i);
    issue_v_i <= 1'b1;
    fu_op_i   <= op;
    opw_i     <= w;
    rs1_i     <= a;
    rs2_i     <= b;
    rd_addr_i <= 5'($urandom);
    @(posedge clk_i);
    issue_v_i <= 1'b0;
    if (poke)
    begin
      repeat (3) @(posedge clk_i);
      issue_v_i <= 1'b1;
      fu_op_i   <= e_op_divu;
      opw_i     <= 1'b0;
      rs1_i     <= {$urandom, $urandom};
      rd_addr_i <= 5'($urandom);
      @(posedge clk_i);
      issue_v_i <= 1'b0;
    end
    do @(posedge clk_i); while (!wb_v_o);
    repeat (stall) @(posedge clk_i);
    wb_yumi_i <= 1'b1;
    @(posedge clk_i);
    wb_yumi_i <= 1'b0;
  endtask

  task automatic print_test(input string name, input int n_ops, input int errs_before);
    @(posedge clk_i); // Busy checks of the last writeback complete here
    @(negedge clk_i);
    $display("test %s: %0d ops, %0d errors", name, n_ops, err_cnt - errs_before);
  endtask

  // Reference queue tracks accepted issues in order
  always @(posedge clk_i)
  begin
    long_wb_pkt_s pkt;
    if (reset_i)
    begin
      exp_q.delete();
      seen_issue = 1'b0;
    end
    else
    begin
      since_accept = since_accept + 1;
      if (issue_v_i && !busy_o)
      begin
        pkt.rd_addr = rd_addr_i;
        pkt.rd_data = ref_result(fu_op_i, opw_i, rs1_i, rs2_i);
        exp_q.push_back(pkt);
        since_accept = 0;
        acc_cnt++;
        seen_issue = 1'b1;
      end
      if (wb_v_o && wb_yumi_i)
      begin
        if (exp_q.size() > 0)
          void'(exp_q.pop_front());
        wb_cnt++;
      end
    end
    exp_cnt  = exp_q.size();
    exp_data = (exp_cnt > 0) ? exp_q[0].rd_data : '0;
    exp_addr = (exp_cnt > 0) ? exp_q[0].rd_addr : '0;
    prev_data <= wb_data_o;
    prev_addr <= wb_rd_addr_o;
  end

  wb_known_check: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_v_o |-> exp_cnt > 0)
    else fail_check("writeback with no accepted issue pending");
  data_check: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_v_o |-> wb_data_o == exp_data)
    else log_mismatch("wb_data_o", $sampled(exp_data), $sampled(wb_data_o));
  addr_check: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_v_o |-> wb_rd_addr_o == exp_addr)
    else log_mismatch("wb_rd_addr_o", $sampled(exp_addr), $sampled(wb_rd_addr_o));
  latency_check: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(wb_v_o) |-> since_accept == latency_c)
    else log_mismatch("wb_v_o latency", latency_c, $sampled(since_accept));
  busy_set_check: assert property (@(posedge clk_i) disable iff (reset_i)
    (issue_v_i && !busy_o) |=> busy_o)
    else fail_check("busy_o did not rise after an accepted issue");
  busy_hold_check: assert property (@(posedge clk_i) disable iff (reset_i)
    (busy_o && !(wb_v_o && wb_yumi_i)) |=> busy_o)
    else fail_check("busy_o dropped before the writeback was taken");
  busy_clear_check: assert property (@(posedge clk_i) disable iff (reset_i)
    (wb_v_o && wb_yumi_i) |=> !busy_o)
    else fail_check("busy_o still high after the writeback was taken");
  hold_v_check: assert property (@(posedge clk_i) disable iff (reset_i)
    (wb_v_o && !wb_yumi_i) |=> wb_v_o)
    else fail_check("wb_v_o dropped without wb_yumi_i");
  hold_data_check: assert property (@(posedge clk_i) disable iff (reset_i)
    (wb_v_o && !wb_yumi_i) |=> wb_data_o == prev_data)
    else log_mismatch("wb_data_o hold", $sampled(prev_data), $sampled(wb_data_o));
  hold_addr_check: assert property (@(posedge clk_i) disable iff (reset_i)
    (wb_v_o && !wb_yumi_i) |=> wb_rd_addr_o == prev_addr)
    else log_mismatch("wb_rd_addr_o hold", $sampled(prev_addr), $sampled(wb_rd_addr_o));
  reset_check: assert property (@(posedge clk_i) disable iff (reset_i)
    !seen_issue |-> (!busy_o && !wb_v_o))
    else fail_check("busy_o or wb_v_o high after reset before any issue");

  initial
  begin
    int e0;
    void'($urandom(32'h9d09));
    issue_v_i = 1'b0;
    fu_op_i   = e_op_mulh;
    opw_i     = 1'b0;
    rs1_i     = '0;
    rs2_i     = '0;
    rd_addr_i = '0;
    wb_yumi_i = 1'b0;
    do @(posedge clk_i); while (reset_i);

    e0 = err_cnt;
    repeat (10) @(posedge clk_i);
    print_test("reset", 0, e0);

    e0 = err_cnt;
    for (int i = 0; i < 20; i++)
      run_op(long_op_e'($urandom_range(0, 2)), 1'b0, pick_operand(), pick_operand(), 0, 1'b0);
    print_test("mulh", 20, e0);

    e0 = err_cnt;
    for (int k = 3; k <= 6; k++)
    begin
      run_op(long_op_e'(k), 1'b0, pick_operand(), '0, 0, 1'b0); // Divide by zero
      run_op(long_op_e'(k), 1'b0, 64'h8000_0000_0000_0000, '1, 0, 1'b0);
    end
    for (int i = 0; i < 12; i++)
      run_op(long_op_e'($urandom_range(3, 6)), 1'b0, pick_operand(), pick_operand(), 0, 1'b0);
    print_test("div_rem", 20, e0);

    e0 = err_cnt;
    for (int k = 3; k <= 6; k++)
    begin
      run_op(long_op_e'(k), 1'b1, {$urandom, $urandom}, {$urandom, 32'h0}, 0, 1'b0);
      run_op(long_op_e'(k), 1'b1, {$urandom, 32'h8000_0000}, {$urandom, 32'hffff_ffff}, 0, 1'b0);
    end
    for (int i = 0; i < 16; i++)
      run_op(long_op_e'($urandom_range(3, 6)), 1'b1, pick_operand(), pick_operand(), 0, 1'b0);
    print_test("div_rem_w", 24, e0);

    e0 = err_cnt;
    for (int i = 0; i < 6; i++)
      run_op(long_op_e'($urandom_range(0, 6)), 1'b0, pick_operand(), pick_operand(), 0, 1'b1);
    print_test("busy", 6, e0);

    e0 = err_cnt;
    for (int i = 0; i < 10; i++)
      run_op(long_op_e'($urandom_range(0, 6)), 1'b0, pick_operand(), pick_operand(),
             $urandom_range(1, 8), 1'b0);
    print_test("backpressure", 10, e0);

    repeat (5) @(posedge clk_i);
    count_check: assert (acc_cnt == wb_cnt && exp_cnt == 0)
      else fail_check("number of writebacks differs from number of accepted issues");
    $display("Done: 6 tests, %0d issues, %0d writebacks, %0d errors", acc_cnt, wb_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  initial
  begin
    #((n_ops_c * 80 + 1000) * clk_period_c);
    $display("Timeout: the run did not finish within %0d cycles", n_ops_c * 80 + 1000);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
